/* src/host_mon_pkg.sv */
package host_mon_pkg;

  // Configuration port
  localparam int unsigned LiteAddrWidth = 8;
  localparam int unsigned LiteDataWidth = 32;

  typedef logic [LiteAddrWidth-1:0] lite_addr_t;
  typedef logic [LiteDataWidth-1:0] lite_data_t;
  typedef logic [1:0]               resp_t;

  localparam resp_t      RespOkay     = 2'd0;
  localparam resp_t      RespSlvErr   = 2'd2;
  localparam lite_data_t UnmappedData = 32'hdeadf000;

  // Event sources where 6 and 7 count nothing
  typedef enum logic [2:0] {
    EvtNone   = 3'd0,
    EvtRdHit  = 3'd1,
    EvtRdMiss = 3'd2,
    EvtWrHit  = 3'd3,
    EvtWrMiss = 3'd4,
    EvtDma    = 3'd5
  } evt_src_e;

  localparam int unsigned MaxCounters = 4;

  // Register map with one group per 16 bytes
  localparam lite_addr_t CntBase = 8'h00;
  localparam lite_addr_t SelBase = 8'h10;
  localparam lite_addr_t ThrBase = 8'h20;
  localparam lite_addr_t IrqAddr = 8'h30;

endpackage

/* src/cfg_lite_slave.sv */
`timescale 1ns/1ps

module cfg_lite_slave
  import host_mon_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  // Read channel
  input  logic       cfg_ar_valid_i,
  output logic       cfg_ar_ready_o,
  input  lite_addr_t cfg_ar_addr_i,
  output logic       cfg_r_valid_o,
  input  logic       cfg_r_ready_i,
  output lite_data_t cfg_r_data_o,
  output resp_t      cfg_r_resp_o,
  // Write channel
  input  logic       cfg_aw_valid_i,
  output logic       cfg_aw_ready_o,
  input  lite_addr_t cfg_aw_addr_i,
  input  logic       cfg_w_valid_i,
  output logic       cfg_w_ready_o,
  input  lite_data_t cfg_w_data_i,
  output logic       cfg_b_valid_o,
  input  logic       cfg_b_ready_i,
  output resp_t      cfg_b_resp_o,
  // Register side
  output logic       rd_en_o,
  output lite_addr_t rd_addr_o,
  input  lite_data_t rd_data_i,
  input  logic       rd_err_i,
  output logic       wr_en_o,
  output lite_addr_t wr_addr_o,
  output lite_data_t wr_data_o,
  input  logic       wr_err_i
);

  logic       r_pending_q;
  lite_data_t r_data_q;
  resp_t      r_resp_q;
  logic       b_pending_q;
  resp_t      b_resp_q;

  assign cfg_ar_ready_o = !r_pending_q;
  assign rd_en_o        = cfg_ar_valid_i && !r_pending_q;
  assign rd_addr_o      = cfg_ar_addr_i;

  // Address and data are taken together
  assign cfg_aw_ready_o = !b_pending_q;
  assign cfg_w_ready_o  = !b_pending_q;
  assign wr_en_o        = cfg_aw_valid_i && cfg_w_valid_i && !b_pending_q;
  assign wr_addr_o      = cfg_aw_addr_i;
  assign wr_data_o      = cfg_w_data_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_pending_q <= 1'b0;
      r_data_q    <= '0;
      r_resp_q    <= RespOkay;
    end else if (rd_en_o) begin
      r_pending_q <= 1'b1;
      r_data_q    <= rd_data_i;
      r_resp_q    <= rd_err_i ? RespSlvErr : RespOkay;
    end else if (r_pending_q && cfg_r_ready_i) begin
      r_pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_pending_q <= 1'b0;
      b_resp_q    <= RespOkay;
    end else if (wr_en_o) begin
      b_pending_q <= 1'b1;
      b_resp_q    <= wr_err_i ? RespSlvErr : RespOkay;
    end else if (b_pending_q && cfg_b_ready_i) begin
      b_pending_q <= 1'b0;
    end
  end

  assign cfg_r_valid_o = r_pending_q;
  assign cfg_r_data_o  = r_data_q;
  assign cfg_r_resp_o  = r_resp_q;
  assign cfg_b_valid_o = b_pending_q;
  assign cfg_b_resp_o  = b_resp_q;

  // Held responses must not change before the host takes them
  assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_r_valid_o && !cfg_r_ready_i |=>
      cfg_r_valid_o && $stable(cfg_r_data_o) && $stable(cfg_r_resp_o));

  assert property (@(posedge clk_i) disable iff (rst_i)
    cfg_b_valid_o && !cfg_b_ready_i |=> cfg_b_valid_o && $stable(cfg_b_resp_o));

endmodule

/* src/host_regs.sv */
`timescale 1ns/1ps

module host_regs
  import host_mon_pkg::*;
#(
  parameter int unsigned NumCounters  = 4,
  parameter int unsigned CounterWidth = 32
) (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    rd_en_i,
  input  lite_addr_t                              rd_addr_i,
  output lite_data_t                              rd_data_o,
  output logic                                    rd_err_o,
  input  logic                                    wr_en_i,
  input  lite_addr_t                              wr_addr_i,
  input  lite_data_t                              wr_data_i,
  output logic                                    wr_err_o,
  input  logic [NumCounters-1:0][CounterWidth-1:0] cnt_value_i,
  input  logic [NumCounters-1:0]                  irq_status_i,
  output evt_src_e [NumCounters-1:0]              evt_sel_o,
  output logic [NumCounters-1:0][CounterWidth-1:0] threshold_o,
  output logic [NumCounters-1:0]                  cnt_load_o,
  output logic [CounterWidth-1:0]                 cnt_load_data_o,
  output logic [NumCounters-1:0]                  irq_clear_o
);

  localparam int unsigned IdxWidth = $clog2(MaxCounters);
  localparam lite_addr_t  GrpMask  = 8'hf0;

  evt_src_e [NumCounters-1:0]               evt_sel_q;
  logic [NumCounters-1:0][CounterWidth-1:0] thr_q;
  logic [IdxWidth-1:0]                      rd_idx;
  logic [IdxWidth-1:0]                      wr_idx;
  lite_addr_t                               wr_grp;
  logic                                     wr_hit;

  function automatic logic addr_mapped(lite_addr_t addr);
    logic idx_ok;
    idx_ok = int'(addr[2 +: IdxWidth]) < NumCounters;
    if (addr[1:0] != 2'b00) begin
      return 1'b0;
    end
    case (addr & GrpMask)
      CntBase, SelBase, ThrBase: return idx_ok;
      IrqAddr:                   return addr[3:2] == 2'b00;
      default:                   return 1'b0;
    endcase
  endfunction

  assign rd_idx = rd_addr_i[2 +: IdxWidth];
  assign wr_idx = wr_addr_i[2 +: IdxWidth];
  assign wr_grp = wr_addr_i & GrpMask;
  assign wr_hit = wr_en_i && addr_mapped(wr_addr_i);

  always_comb begin
    rd_data_o = '0;
    rd_err_o  = 1'b0;
    if (rd_en_i) begin
      if (!addr_mapped(rd_addr_i)) begin
        rd_data_o = UnmappedData;
        rd_err_o  = 1'b1;
      end else begin
        case (rd_addr_i & GrpMask)
          CntBase: rd_data_o = LiteDataWidth'(cnt_value_i[rd_idx]);
          SelBase: rd_data_o = LiteDataWidth'(evt_sel_q[rd_idx]);
          ThrBase: rd_data_o = LiteDataWidth'(thr_q[rd_idx]);
          default: rd_data_o = LiteDataWidth'(irq_status_i);
        endcase
      end
    end
  end

  // Load strobes and clear mask go straight to the counter bank
  always_comb begin
    cnt_load_o  = '0;
    irq_clear_o = '0;
    if (wr_hit && wr_grp == CntBase) begin
      cnt_load_o[wr_idx] = 1'b1;
    end
    if (wr_hit && wr_grp == IrqAddr) begin
      irq_clear_o = wr_data_i[NumCounters-1:0];
    end
  end

  assign wr_err_o        = wr_en_i && !addr_mapped(wr_addr_i);
  assign cnt_load_data_o = wr_data_i[CounterWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NumCounters; i++) begin
        evt_sel_q[i] <= EvtNone;
        thr_q[i]     <= '0;
      end
    end else if (wr_hit && wr_grp == SelBase) begin
      evt_sel_q[wr_idx] <= evt_src_e'(wr_data_i[2:0]);
    end else if (wr_hit && wr_grp == ThrBase) begin
      thr_q[wr_idx] <= wr_data_i[CounterWidth-1:0];
    end
  end

  assign evt_sel_o   = evt_sel_q;
  assign threshold_o = thr_q;

endmodule

/* src/pmu_counter_bank.sv */
`timescale 1ns/1ps

module pmu_counter_bank
  import host_mon_pkg::*;
#(
  parameter int unsigned NumCounters  = 4,
  parameter int unsigned CounterWidth = 32
) (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  // LLC event levels
  input  logic                                    llc_read_hit_i,
  input  logic                                    llc_read_miss_i,
  input  logic                                    llc_write_hit_i,
  input  logic                                    llc_write_miss_i,
  input  logic                                    dma_evt_i,
  // Configuration from the register block
  input  evt_src_e [NumCounters-1:0]              evt_sel_i,
  input  logic [NumCounters-1:0][CounterWidth-1:0] threshold_i,
  input  logic [NumCounters-1:0]                  cnt_load_i,
  input  logic [CounterWidth-1:0]                 cnt_load_data_i,
  input  logic [NumCounters-1:0]                  irq_clear_i,
  output logic [NumCounters-1:0][CounterWidth-1:0] cnt_value_o,
  output logic [NumCounters-1:0]                  irq_status_o
);

  logic [NumCounters-1:0][CounterWidth-1:0] cnt_q;
  logic [NumCounters-1:0][CounterWidth-1:0] cnt_inc;
  logic [NumCounters-1:0]                   irq_q;
  logic [NumCounters-1:0]                   evt_hit;
  logic [NumCounters-1:0]                   thr_hit;

  always_comb begin
    for (int i = 0; i < NumCounters; i++) begin
      case (evt_sel_i[i])
        EvtRdHit:  evt_hit[i] = llc_read_hit_i;
        EvtRdMiss: evt_hit[i] = llc_read_miss_i;
        EvtWrHit:  evt_hit[i] = llc_write_hit_i;
        EvtWrMiss: evt_hit[i] = llc_write_miss_i;
        EvtDma:    evt_hit[i] = dma_evt_i;
        default:   evt_hit[i] = 1'b0;
      endcase
      // Wraps at the counter width
      cnt_inc[i] = cnt_q[i] + 1'b1;
      // Only a real increment can hit the threshold
      thr_hit[i] = evt_hit[i] && !cnt_load_i[i] && (threshold_i[i] != '0) &&
                   (cnt_inc[i] == threshold_i[i]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < NumCounters; i++) begin
        if (cnt_load_i[i]) begin
          cnt_q[i] <= cnt_load_data_i;
        end else if (evt_hit[i]) begin
          cnt_q[i] <= cnt_inc[i];
        end
      end
    end
  end

  // Sticky status where a new hit beats a clear
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_q <= '0;
    end else begin
      irq_q <= thr_hit | (irq_q & ~irq_clear_i);
    end
  end

  assign cnt_value_o  = cnt_q;
  assign irq_status_o = irq_q;

  // A status bit rises only when its counter has just reached a nonzero threshold
  for (genvar g = 0; g < NumCounters; g++) begin : g_irq_chk
    assert property (@(posedge clk_i) disable iff (rst_i)
      $rose(irq_status_o[g]) |->
        (cnt_value_o[g] == $past(threshold_i[g])) && ($past(threshold_i[g]) != '0));
  end

endmodule

/* src/dma_evt_rx.sv */
`timescale 1ns/1ps

module dma_evt_rx (
  input  logic clk_i,
  input  logic rst_i,
  // Toggle from the cluster domain
  input  logic dma_evt_valid_i,
  output logic dma_evt_o,
  output logic dma_evt_ack_o
);

  logic sync_q1;
  logic sync_q2;
  logic level_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
      level_q <= 1'b0;
    end else begin
      sync_q1 <= dma_evt_valid_i;
      sync_q2 <= sync_q1;
      level_q <= sync_q2;
    end
  end

  // One pulse per level change that is counted when the ack follows
  assign dma_evt_o     = sync_q2 ^ level_q;
  assign dma_evt_ack_o = level_q;

  // Each pulse lasts one cycle
  assert property (@(posedge clk_i) disable iff (rst_i)
    dma_evt_o |=> !dma_evt_o);

endmodule

/* src/host_event_monitor.sv */
`timescale 1ns/1ps

module host_event_monitor
  import host_mon_pkg::*;
#(
  parameter int unsigned NumCounters  = 4,
  parameter int unsigned CounterWidth = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Configuration port, read
  input  logic                   cfg_ar_valid_i,
  output logic                   cfg_ar_ready_o,
  input  lite_addr_t             cfg_ar_addr_i,
  output logic                   cfg_r_valid_o,
  input  logic                   cfg_r_ready_i,
  output lite_data_t             cfg_r_data_o,
  output resp_t                  cfg_r_resp_o,
  // Configuration port, write
  input  logic                   cfg_aw_valid_i,
  output logic                   cfg_aw_ready_o,
  input  lite_addr_t             cfg_aw_addr_i,
  input  logic                   cfg_w_valid_i,
  output logic                   cfg_w_ready_o,
  input  lite_data_t             cfg_w_data_i,
  output logic                   cfg_b_valid_o,
  input  logic                   cfg_b_ready_i,
  output resp_t                  cfg_b_resp_o,
  // Events
  input  logic                   llc_read_hit_i,
  input  logic                   llc_read_miss_i,
  input  logic                   llc_write_hit_i,
  input  logic                   llc_write_miss_i,
  input  logic                   dma_evt_valid_i,
  output logic                   dma_evt_ack_o,
  output logic [NumCounters-1:0] pmu_irq_o
);

  logic                                     rd_en;
  lite_addr_t                               rd_addr;
  lite_data_t                               rd_data;
  logic                                     rd_err;
  logic                                     wr_en;
  lite_addr_t                               wr_addr;
  lite_data_t                               wr_data;
  logic                                     wr_err;
  evt_src_e [NumCounters-1:0]               evt_sel;
  logic [NumCounters-1:0][CounterWidth-1:0] threshold;
  logic [NumCounters-1:0]                   cnt_load;
  logic [CounterWidth-1:0]                  cnt_load_data;
  logic [NumCounters-1:0]                   irq_clear;
  logic [NumCounters-1:0][CounterWidth-1:0] cnt_value;
  logic [NumCounters-1:0]                   irq_status;
  logic                                     dma_evt;

  cfg_lite_slave i_cfg_lite_slave (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .cfg_ar_valid_i ( cfg_ar_valid_i ),
    .cfg_ar_ready_o ( cfg_ar_ready_o ),
    .cfg_ar_addr_i  ( cfg_ar_addr_i  ),
    .cfg_r_valid_o  ( cfg_r_valid_o  ),
    .cfg_r_ready_i  ( cfg_r_ready_i  ),
    .cfg_r_data_o   ( cfg_r_data_o   ),
    .cfg_r_resp_o   ( cfg_r_resp_o   ),
    .cfg_aw_valid_i ( cfg_aw_valid_i ),
    .cfg_aw_ready_o ( cfg_aw_ready_o ),
    .cfg_aw_addr_i  ( cfg_aw_addr_i  ),
    .cfg_w_valid_i  ( cfg_w_valid_i  ),
    .cfg_w_ready_o  ( cfg_w_ready_o  ),
    .cfg_w_data_i   ( cfg_w_data_i   ),
    .cfg_b_valid_o  ( cfg_b_valid_o  ),
    .cfg_b_ready_i  ( cfg_b_ready_i  ),
    .cfg_b_resp_o   ( cfg_b_resp_o   ),
    .rd_en_o        ( rd_en          ),
    .rd_addr_o      ( rd_addr        ),
    .rd_data_i      ( rd_data        ),
    .rd_err_i       ( rd_err         ),
    .wr_en_o        ( wr_en          ),
    .wr_addr_o      ( wr_addr        ),
    .wr_data_o      ( wr_data        ),
    .wr_err_i       ( wr_err         )
  );

  host_regs #(
    .NumCounters  ( NumCounters  ),
    .CounterWidth ( CounterWidth )
  ) i_host_regs (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .rd_en_i         ( rd_en         ),
    .rd_addr_i       ( rd_addr       ),
    .rd_data_o       ( rd_data       ),
    .rd_err_o        ( rd_err        ),
    .wr_en_i         ( wr_en         ),
    .wr_addr_i       ( wr_addr       ),
    .wr_data_i       ( wr_data       ),
    .wr_err_o        ( wr_err        ),
    .cnt_value_i     ( cnt_value     ),
    .irq_status_i    ( irq_status    ),
    .evt_sel_o       ( evt_sel       ),
    .threshold_o     ( threshold     ),
    .cnt_load_o      ( cnt_load      ),
    .cnt_load_data_o ( cnt_load_data ),
    .irq_clear_o     ( irq_clear     )
  );

  pmu_counter_bank #(
    .NumCounters  ( NumCounters  ),
    .CounterWidth ( CounterWidth )
  ) i_pmu_counter_bank (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .llc_read_hit_i   ( llc_read_hit_i   ),
    .llc_read_miss_i  ( llc_read_miss_i  ),
    .llc_write_hit_i  ( llc_write_hit_i  ),
    .llc_write_miss_i ( llc_write_miss_i ),
    .dma_evt_i        ( dma_evt          ),
    .evt_sel_i        ( evt_sel          ),
    .threshold_i      ( threshold        ),
    .cnt_load_i       ( cnt_load         ),
    .cnt_load_data_i  ( cnt_load_data    ),
    .irq_clear_i      ( irq_clear        ),
    .cnt_value_o      ( cnt_value        ),
    .irq_status_o     ( irq_status       )
  );

  dma_evt_rx i_dma_evt_rx (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .dma_evt_valid_i ( dma_evt_valid_i ),
    .dma_evt_o       ( dma_evt         ),
    .dma_evt_ack_o   ( dma_evt_ack_o   )
  );

  assign pmu_irq_o = irq_status;

endmodule

/* dv/tb_host_event_monitor.sv */
`timescale 1ns/1ps

module tb_host_event_monitor
  import host_mon_pkg::*;
();

  localparam int unsigned NumCounters   = 4;
  localparam int          TimeoutCycles = 100;

  typedef enum logic [2:0] {
    OpWr  = 3'd0,
    OpRd  = 3'd1,
    OpLlc = 3'd2,
    OpDma = 3'd3,
    OpIrq = 3'd4
  } op_e;

  // For OpLlc the address field holds the LLC input index
  typedef struct packed {
    op_e        op;
    lite_addr_t addr;
    lite_data_t data;
    lite_data_t exp_data;
    resp_t      exp_resp;
  } row_t;

  logic                   clk_i;
  logic                   rst_i;
  logic                   cfg_ar_valid_i;
  logic                   cfg_ar_ready_o;
  lite_addr_t             cfg_ar_addr_i;
  logic                   cfg_r_valid_o;
  logic                   cfg_r_ready_i;
  lite_data_t             cfg_r_data_o;
  resp_t                  cfg_r_resp_o;
  logic                   cfg_aw_valid_i;
  logic                   cfg_aw_ready_o;
  lite_addr_t             cfg_aw_addr_i;
  logic                   cfg_w_valid_i;
  logic                   cfg_w_ready_o;
  lite_data_t             cfg_w_data_i;
  logic                   cfg_b_valid_o;
  logic                   cfg_b_ready_i;
  resp_t                  cfg_b_resp_o;
  logic                   llc_read_hit_i;
  logic                   llc_read_miss_i;
  logic                   llc_write_hit_i;
  logic                   llc_write_miss_i;
  logic                   dma_evt_valid_i;
  logic                   dma_evt_ack_o;
  logic [NumCounters-1:0] pmu_irq_o;

  row_t        rows[$];
  logic [31:0] lfsr_q;
  int          errors;
  bit          aborted;

  host_event_monitor i_host_event_monitor (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .cfg_ar_valid_i   ( cfg_ar_valid_i   ),
    .cfg_ar_ready_o   ( cfg_ar_ready_o   ),
    .cfg_ar_addr_i    ( cfg_ar_addr_i    ),
    .cfg_r_valid_o    ( cfg_r_valid_o    ),
    .cfg_r_ready_i    ( cfg_r_ready_i    ),
    .cfg_r_data_o     ( cfg_r_data_o     ),
    .cfg_r_resp_o     ( cfg_r_resp_o     ),
    .cfg_aw_valid_i   ( cfg_aw_valid_i   ),
    .cfg_aw_ready_o   ( cfg_aw_ready_o   ),
    .cfg_aw_addr_i    ( cfg_aw_addr_i    ),
    .cfg_w_valid_i    ( cfg_w_valid_i    ),
    .cfg_w_ready_o    ( cfg_w_ready_o    ),
    .cfg_w_data_i     ( cfg_w_data_i     ),
    .cfg_b_valid_o    ( cfg_b_valid_o    ),
    .cfg_b_ready_i    ( cfg_b_ready_i    ),
    .cfg_b_resp_o     ( cfg_b_resp_o     ),
    .llc_read_hit_i   ( llc_read_hit_i   ),
    .llc_read_miss_i  ( llc_read_miss_i  ),
    .llc_write_hit_i  ( llc_write_hit_i  ),
    .llc_write_miss_i ( llc_write_miss_i ),
    .dma_evt_valid_i  ( dma_evt_valid_i  ),
    .dma_evt_ack_o    ( dma_evt_ack_o    ),
    .pmu_irq_o        ( pmu_irq_o        )
  );

  always #4 clk_i = ~clk_i;

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic tick_wait(input string what, inout int waited);
    @(negedge clk_i);
    waited++;
    if (waited > TimeoutCycles && !aborted) begin
      $display("Gave up after %0d cycles waiting for the %s", TimeoutCycles, what);
      aborted = 1'b1;
    end
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h80200003;
    end
    return next;
  endfunction

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      value  = (value << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic do_write(input lite_addr_t addr, input lite_data_t data, input resp_t exp_resp);
    int    waited;
    int    delay;
    resp_t held_resp;
    @(negedge clk_i);
    cfg_aw_valid_i = 1'b1;
    cfg_aw_addr_i  = addr;
    cfg_w_valid_i  = 1'b1;
    cfg_w_data_i   = data;
    waited = 0;
    while (!(cfg_aw_ready_o && cfg_w_ready_o) && !aborted) begin
      tick_wait("write address ready", waited);
    end
    @(negedge clk_i);
    cfg_aw_valid_i = 1'b0;
    cfg_w_valid_i  = 1'b0;
    waited = 0;
    while (!cfg_b_valid_o && !aborted) begin
      tick_wait("write response", waited);
    end
    if (aborted) begin
      return;
    end
    held_resp = cfg_b_resp_o;
    check("aw/w ready while held", 32'(cfg_aw_ready_o || cfg_w_ready_o), 32'd0);
    take_bits(2, delay);
    repeat (delay) begin
      @(negedge clk_i);
      check("held b_valid", 32'(cfg_b_valid_o), 32'd1);
      check("held b_resp", 32'(cfg_b_resp_o), 32'(held_resp));
    end
    check($sformatf("b_resp of write to %h", addr), 32'(cfg_b_resp_o), 32'(exp_resp));
    cfg_b_ready_i = 1'b1;
    @(negedge clk_i);
    cfg_b_ready_i = 1'b0;
  endtask

  task automatic do_read(input lite_addr_t addr, input lite_data_t exp_data,
                         input resp_t exp_resp);
    int         waited;
    int         delay;
    lite_data_t held_data;
    resp_t      held_resp;
    @(negedge clk_i);
    cfg_ar_valid_i = 1'b1;
    cfg_ar_addr_i  = addr;
    waited = 0;
    while (!cfg_ar_ready_o && !aborted) begin
      tick_wait("read address ready", waited);
    end
    @(negedge clk_i);
    cfg_ar_valid_i = 1'b0;
    waited = 0;
    while (!cfg_r_valid_o && !aborted) begin
      tick_wait("read response", waited);
    end
    if (aborted) begin
      return;
    end
    held_data = cfg_r_data_o;
    held_resp = cfg_r_resp_o;
    check("ar_ready while held", 32'(cfg_ar_ready_o), 32'd0);
    take_bits(2, delay);
    repeat (delay) begin
      @(negedge clk_i);
      check("held r_valid", 32'(cfg_r_valid_o), 32'd1);
      check("held r_data", cfg_r_data_o, held_data);
      check("held r_resp", 32'(cfg_r_resp_o), 32'(held_resp));
    end
    check($sformatf("r_data from %h", addr), cfg_r_data_o, exp_data);
    check($sformatf("r_resp from %h", addr), 32'(cfg_r_resp_o), 32'(exp_resp));
    cfg_r_ready_i = 1'b1;
    @(negedge clk_i);
    cfg_r_ready_i = 1'b0;
  endtask

  task automatic set_llc(input int idx, input logic level);
    case (idx)
      0:       llc_read_hit_i   = level;
      1:       llc_read_miss_i  = level;
      2:       llc_write_hit_i  = level;
      default: llc_write_miss_i = level;
    endcase
  endtask

  task automatic drive_llc(input int idx, input int cycles);
    @(negedge clk_i);
    repeat (cycles) begin
      set_llc(idx, 1'b1);
      @(negedge clk_i);
    end
    set_llc(idx, 1'b0);
  endtask

  // Each toggle is one event and the ack shows it was counted
  task automatic toggle_dma(input int toggles);
    int waited;
    repeat (toggles) begin
      @(negedge clk_i);
      dma_evt_valid_i = ~dma_evt_valid_i;
      waited = 0;
      while (dma_evt_ack_o !== dma_evt_valid_i && !aborted) begin
        tick_wait("DMA acknowledge", waited);
      end
      if (aborted) begin
        return;
      end
    end
  endtask

  task automatic add_row(input op_e op, input int addr, input lite_data_t data,
                         input lite_data_t exp_data, input resp_t exp_resp);
    rows.push_back('{op, lite_addr_t'(addr), data, exp_data, exp_resp});
  endtask

  task automatic build_table();
    for (int i = 0; i < NumCounters; i++) begin
      add_row(OpRd, CntBase + 4 * i, 0, 0, RespOkay);
      add_row(OpRd, SelBase + 4 * i, 0, 0, RespOkay);
      add_row(OpRd, ThrBase + 4 * i, 0, 0, RespOkay);
    end
    add_row(OpRd, IrqAddr, 0, 0, RespOkay);
    add_row(OpIrq, 0, 0, 0, RespOkay);
    // Selects keep three bits
    add_row(OpWr, SelBase + 0, 32'h1, 0, RespOkay);
    add_row(OpWr, SelBase + 4, 32'ha, 0, RespOkay);
    add_row(OpWr, SelBase + 8, 32'h3, 0, RespOkay);
    add_row(OpWr, SelBase + 12, 32'hfc, 0, RespOkay);
    add_row(OpRd, SelBase + 0, 0, 32'h1, RespOkay);
    add_row(OpRd, SelBase + 4, 0, 32'h2, RespOkay);
    add_row(OpRd, SelBase + 8, 0, 32'h3, RespOkay);
    add_row(OpRd, SelBase + 12, 0, 32'h4, RespOkay);
    // Thresholds well above the counts reached below
    add_row(OpWr, ThrBase + 0, 32'ha5a5a5a5, 0, RespOkay);
    add_row(OpWr, ThrBase + 4, 32'h0001ffff, 0, RespOkay);
    add_row(OpWr, ThrBase + 8, 32'h80000000, 0, RespOkay);
    add_row(OpWr, ThrBase + 12, 32'h12345678, 0, RespOkay);
    add_row(OpRd, ThrBase + 0, 0, 32'ha5a5a5a5, RespOkay);
    add_row(OpRd, ThrBase + 4, 0, 32'h0001ffff, RespOkay);
    add_row(OpRd, ThrBase + 8, 0, 32'h80000000, RespOkay);
    add_row(OpRd, ThrBase + 12, 0, 32'h12345678, RespOkay);
    // One burst per LLC input
    add_row(OpLlc, 0, 5, 0, RespOkay);
    add_row(OpLlc, 1, 7, 0, RespOkay);
    add_row(OpLlc, 2, 3, 0, RespOkay);
    add_row(OpLlc, 3, 9, 0, RespOkay);
    add_row(OpRd, CntBase + 0, 0, 5, RespOkay);
    add_row(OpRd, CntBase + 4, 0, 7, RespOkay);
    add_row(OpRd, CntBase + 8, 0, 3, RespOkay);
    add_row(OpRd, CntBase + 12, 0, 9, RespOkay);
    add_row(OpWr, CntBase + 4, 100, 0, RespOkay);
    add_row(OpLlc, 1, 4, 0, RespOkay);
    add_row(OpRd, CntBase + 4, 0, 104, RespOkay);
    add_row(OpRd, CntBase + 0, 0, 5, RespOkay);
    // Counter 2 moves to the DMA event
    add_row(OpWr, SelBase + 8, 32'h5, 0, RespOkay);
    add_row(OpWr, CntBase + 8, 0, 0, RespOkay);
    add_row(OpDma, 0, 6, 0, RespOkay);
    add_row(OpRd, CntBase + 8, 0, 6, RespOkay);
    add_row(OpRd, CntBase + 12, 0, 9, RespOkay);
    // Threshold of 5 on counter 3
    add_row(OpWr, CntBase + 12, 0, 0, RespOkay);
    add_row(OpWr, ThrBase + 12, 5, 0, RespOkay);
    add_row(OpLlc, 3, 4, 0, RespOkay);
    add_row(OpIrq, 0, 0, 32'h0, RespOkay);
    add_row(OpLlc, 3, 1, 0, RespOkay);
    add_row(OpIrq, 0, 0, 32'h8, RespOkay);
    add_row(OpRd, IrqAddr, 0, 32'h8, RespOkay);
    add_row(OpLlc, 3, 3, 0, RespOkay);
    add_row(OpIrq, 0, 0, 32'h8, RespOkay);
    add_row(OpWr, IrqAddr, 32'h8, 0, RespOkay);
    add_row(OpIrq, 0, 0, 32'h0, RespOkay);
    add_row(OpRd, IrqAddr, 0, 32'h0, RespOkay);
    add_row(OpRd, CntBase + 12, 0, 8, RespOkay);
    // Unmapped locations
    add_row(OpRd, 8'h34, 0, UnmappedData, RespSlvErr);
    add_row(OpRd, 8'h40, 0, UnmappedData, RespSlvErr);
    add_row(OpWr, 8'h22, 0, 0, RespSlvErr);
    add_row(OpRd, ThrBase + 0, 0, 32'ha5a5a5a5, RespOkay);
    add_row(OpWr, 8'h50, 32'hffffffff, 0, RespSlvErr);
    add_row(OpRd, CntBase + 0, 0, 5, RespOkay);
  endtask

  task automatic apply_row(input row_t row);
    case (row.op)
      OpWr:  do_write(row.addr, row.data, row.exp_resp);
      OpRd:  do_read(row.addr, row.exp_data, row.exp_resp);
      OpLlc: drive_llc(int'(row.addr), int'(row.data));
      OpDma: toggle_dma(int'(row.data));
      default: begin
        @(negedge clk_i);
        check("pmu_irq_o", 32'(pmu_irq_o), row.exp_data);
      end
    endcase
  endtask

  initial begin
    clk_i            = 1'b0;
    rst_i            = 1'b1;
    cfg_ar_valid_i   = 1'b0;
    cfg_ar_addr_i    = '0;
    cfg_r_ready_i    = 1'b0;
    cfg_aw_valid_i   = 1'b0;
    cfg_aw_addr_i    = '0;
    cfg_w_valid_i    = 1'b0;
    cfg_w_data_i     = '0;
    cfg_b_ready_i    = 1'b0;
    llc_read_hit_i   = 1'b0;
    llc_read_miss_i  = 1'b0;
    llc_write_hit_i  = 1'b0;
    llc_write_miss_i = 1'b0;
    dma_evt_valid_i  = 1'b0;
    lfsr_q           = 32'hbf27;
    errors           = 0;
    aborted          = 1'b0;
    build_table();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    check("ar_ready after reset", 32'(cfg_ar_ready_o), 32'd1);
    check("aw_ready after reset", 32'(cfg_aw_ready_o && cfg_w_ready_o), 32'd1);
    check("valids after reset", 32'(cfg_r_valid_o || cfg_b_valid_o), 32'd0);
    check("resps after reset", 32'(cfg_r_resp_o | cfg_b_resp_o), 32'd0);
    check("dma ack after reset", 32'(dma_evt_ack_o), 32'd0);
    foreach (rows[i]) begin
      if (!aborted) begin
        apply_row(rows[i]);
      end
    end
    $display("Errors: %0d, timeouts: %0d", errors, int'(aborted));
    if (errors == 0 && !aborted) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* all.f */
src/host_mon_pkg.sv
src/cfg_lite_slave.sv
src/host_regs.sv
src/pmu_counter_bank.sv
src/dma_evt_rx.sv
src/host_event_monitor.sv
dv/tb_host_event_monitor.sv
